// ==== Makefile ====
TOP := tb_zynq_shell

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
+incdir+verilog
verilog/shell_pkg.sv
verilog/reg_access_if.sv
verilog/word_fifo.sv
verilog/axil_write_ctrl.sv
verilog/axil_read_ctrl.sv
verilog/shell_regmap.sv
verilog/zynq_shell_top.sv
verification/tb_clock_gen.sv
verification/shell_assertions.sv
verification/tb_zynq_shell.sv

// ==== verification/shell_assertions.sv ====
`timescale 1ns/1ns

module shell_assertions
(
   input logic clk_i,
   input logic rstn_i,
   input logic awready_i,
   input logic wready_i,
   input logic bvalid_i,
   input logic bready_i,
   input logic rvalid_i,
   input logic rready_i
);

   // --------------------
   // responses stay up until the master takes them
   a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      bvalid_i && !bready_i |=> bvalid_i)
   else
      $error("write response dropped before bready");

   a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rvalid_i && !rready_i |=> rvalid_i)
   else
      $error("read response dropped before rready");

   // address and data ready pulse together, for one cycle only
   a_ready_pair: assert property (@(posedge clk_i) disable iff (!rstn_i)
      (awready_i || wready_i) |-> awready_i && wready_i ##1 !awready_i && !wready_i)
   else
      $error("awready and wready not a shared single-cycle pulse");

   // nothing pending in the first cycle out of reset
   a_reset_quiet: assert property (@(posedge clk_i) $rose(rstn_i) |-> !bvalid_i && !rvalid_i)
   else
      $error("response valid right after reset release");

endmodule

bind zynq_shell_top shell_assertions u_shell_assertions
(
   .clk_i     (S_AXI_ACLK),
   .rstn_i    (S_AXI_ARESETN),
   .awready_i (s_axi_awready_o),
   .wready_i  (s_axi_wready_o),
   .bvalid_i  (s_axi_bvalid_o),
   .bready_i  (s_axi_bready_i),
   .rvalid_i  (s_axi_rvalid_o),
   .rready_i  (s_axi_rready_i)
);

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 5
)
(
   output logic clk_o,
   output logic rstn_o
);

   // free running clock
   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset low for the first cycles, released on a rising edge
   initial
   begin
      rstn_o <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rstn_o <= 1'b1;
   end

endmodule

// ==== verification/tb_zynq_shell.sv ====
`timescale 1ns/1ns
`include "shell_config.svh"

module tb_zynq_shell;
   import shell_pkg::*;

   localparam int TIMEOUT = 20;

   // byte addresses of the register map
   localparam axi_addr_t A_CSR0  = 5'h00;
   localparam axi_addr_t A_CSR1  = 5'h04;
   localparam axi_addr_t A_FIFO  = 5'h08;
   localparam axi_addr_t A_COUNT = 5'h0C;
   localparam axi_addr_t A_FREE  = 5'h10;
   localparam axi_addr_t A_STAT  = 5'h14;
   localparam axi_addr_t A_NONE  = 5'h18;

   // step kinds
   localparam logic [2:0] OP_WR   = 3'd0;
   localparam logic [2:0] OP_RD   = 3'd1;
   localparam logic [2:0] OP_RDX  = 3'd2;
   localparam logic [2:0] OP_PUSH = 3'd3;
   localparam logic [2:0] OP_POP  = 3'd4;
   localparam logic [2:0] OP_IDLE = 3'd5;
   localparam logic [2:0] OP_STAT = 3'd6;

   typedef struct packed
   {
      logic [2:0] op;
      axi_addr_t  addr;
      word_t      exp;
   } step_t;

   localparam int N_STEPS = 45;

   // rd compares with the model, rdx with the constant, idle takes pl ready from exp[0]
   step_t steps [N_STEPS] = '{
      // after reset
      '{OP_IDLE, A_NONE, 32'h1}, '{OP_RDX, A_COUNT, 32'h0}, '{OP_RDX, A_FREE, 32'h4},
      // control registers, then a write that lands nowhere
      '{OP_WR, A_CSR0, 32'h0}, '{OP_WR, A_CSR1, 32'h0}, '{OP_RD, A_CSR0, 32'h0},
      '{OP_RD, A_CSR1, 32'h0}, '{OP_WR, A_NONE, 32'h0}, '{OP_RD, A_CSR0, 32'h0},
      '{OP_RD, A_CSR1, 32'h0},
      // three words down, drained by the client
      '{OP_WR, A_FIFO, 32'h0}, '{OP_WR, A_FIFO, 32'h0}, '{OP_WR, A_FIFO, 32'h0},
      '{OP_RDX, A_FREE, 32'h1}, '{OP_POP, A_NONE, 32'h0}, '{OP_POP, A_NONE, 32'h0},
      '{OP_POP, A_NONE, 32'h0}, '{OP_RDX, A_FREE, 32'h4},
      // five words into four entries, last one lost
      '{OP_WR, A_FIFO, 32'h0}, '{OP_WR, A_FIFO, 32'h0}, '{OP_WR, A_FIFO, 32'h0},
      '{OP_WR, A_FIFO, 32'h0}, '{OP_WR, A_FIFO, 32'h0}, '{OP_RDX, A_FREE, 32'h0},
      '{OP_POP, A_NONE, 32'h0}, '{OP_POP, A_NONE, 32'h0}, '{OP_POP, A_NONE, 32'h0},
      '{OP_POP, A_NONE, 32'h0}, '{OP_IDLE, A_NONE, 32'h1},
      // pl to ps fill, then drain by head reads
      '{OP_PUSH, A_NONE, 32'h0}, '{OP_PUSH, A_NONE, 32'h0}, '{OP_PUSH, A_NONE, 32'h0},
      '{OP_PUSH, A_NONE, 32'h0}, '{OP_IDLE, A_NONE, 32'h0}, '{OP_RDX, A_COUNT, 32'h4},
      '{OP_RD, A_FIFO, 32'h0}, '{OP_RDX, A_COUNT, 32'h3}, '{OP_RD, A_FIFO, 32'h0},
      '{OP_RDX, A_COUNT, 32'h2}, '{OP_RD, A_FIFO, 32'h0}, '{OP_RDX, A_COUNT, 32'h1},
      '{OP_RD, A_FIFO, 32'h0}, '{OP_RDX, A_COUNT, 32'h0},
      // status word
      '{OP_STAT, A_NONE, 32'h0}, '{OP_RD, A_STAT, 32'h0}
   };

   logic        clk;
   logic        rstn;
   axi_addr_t   awaddr;
   logic        awvalid;
   logic        awready;
   word_t       wdata;
   logic        wvalid;
   logic        wready;
   logic        bvalid;
   logic        bready;
   axi_addr_t   araddr;
   logic        arvalid;
   logic        arready;
   word_t       rdata;
   logic        rvalid;
   logic        rready;
   word_t [1:0] csr_out;
   word_t       csr_in;
   word_t       ps_data;
   logic        ps_v;
   logic        ps_yumi;
   word_t       pl_data;
   logic        pl_v;
   logic        pl_ready;

   // scoreboard model of the register map
   word_t       csr_m [2];
   word_t       status_m;
   word_t       ps_q [$];
   word_t       pl_q [$];

   int          checks;
   int          errors;
   int          timeouts;
   bit          abort;
   logic [31:0] lfsr_q;

   tb_clock_gen u_clock_gen
   (
      .clk_o  (clk),
      .rstn_o (rstn)
   );

   zynq_shell_top u_dut
   (
      .S_AXI_ACLK       (clk),
      .S_AXI_ARESETN    (rstn),
      .s_axi_awaddr_i   (awaddr),
      .s_axi_awvalid_i  (awvalid),
      .s_axi_awready_o  (awready),
      .s_axi_wdata_i    (wdata),
      .s_axi_wvalid_i   (wvalid),
      .s_axi_wready_o   (wready),
      .s_axi_bvalid_o   (bvalid),
      .s_axi_bready_i   (bready),
      .s_axi_araddr_i   (araddr),
      .s_axi_arvalid_i  (arvalid),
      .s_axi_arready_o  (arready),
      .s_axi_rdata_o    (rdata),
      .s_axi_rvalid_o   (rvalid),
      .s_axi_rready_i   (rready),
      .csr_data_o       (csr_out),
      .csr_data_i       (csr_in),
      .ps_to_pl_data_o  (ps_data),
      .ps_to_pl_v_o     (ps_v),
      .ps_to_pl_yumi_i  (ps_yumi),
      .pl_to_ps_data_i  (pl_data),
      .pl_to_ps_v_i     (pl_v),
      .pl_to_ps_ready_o (pl_ready)
   );

   // --------------------
   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // one step per bit taken
   task automatic draw_word(output word_t w);
      w = '0;
      for (int i = 0; i < $bits(word_t); i++)
      begin
         w = {w[$bits(word_t)-2:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   function automatic logic sig_level(input string name);
      case (name)
         "S_AXI_ARESETN":    return rstn;
         "s_axi_awready_o":  return awready;
         "s_axi_bvalid_o":   return bvalid;
         "s_axi_arready_o":  return arready;
         "s_axi_rvalid_o":   return rvalid;
         "pl_to_ps_ready_o": return pl_ready;
         "ps_to_pl_v_o":     return ps_v;
         default:            return 1'b0;
      endcase
   endfunction

   // outputs looked at on the falling edge, away from the driving edge
   task automatic wait_high(input string name);
      int n;
      n = 0;
      @(negedge clk);
      while (!sig_level(name) && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (!sig_level(name))
      begin
         timeouts++;
         abort = 1'b1;
         $display("timeout waiting for %s to go high", name);
      end
   endtask

   // --------------------
   // axi master and client side tasks
   task automatic axi_write(input axi_addr_t addr, input word_t data);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      wait_high("s_axi_awready_o");
      // handshake edge
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      wait_high("s_axi_bvalid_o");
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input axi_addr_t addr, output word_t data);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      wait_high("s_axi_arready_o");
      @(posedge clk);
      arvalid <= 1'b0;
      wait_high("s_axi_rvalid_o");
      data = rdata;
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic pl_push(input word_t data);
      @(posedge clk);
      pl_data <= data;
      pl_v    <= 1'b1;
      wait_high("pl_to_ps_ready_o");
      // word enters on this edge
      @(posedge clk);
      pl_v <= 1'b0;
   endtask

   task automatic ps_pop(output word_t data);
      wait_high("ps_to_pl_v_o");
      data = ps_data;
      @(posedge clk);
      ps_yumi <= 1'b1;
      @(posedge clk);
      ps_yumi <= 1'b0;
   endtask

   task automatic idle_check(input logic pl_ready_exp);
      @(negedge clk);
      check_word("s_axi_awready_o", word_t'(awready), '0);
      check_word("s_axi_wready_o", word_t'(wready), '0);
      check_word("s_axi_bvalid_o", word_t'(bvalid), '0);
      check_word("s_axi_arready_o", word_t'(arready), '0);
      check_word("s_axi_rvalid_o", word_t'(rvalid), '0);
      check_word("ps_to_pl_v_o", word_t'(ps_v), '0);
      check_word("pl_to_ps_ready_o", word_t'(pl_ready), word_t'(pl_ready_exp));
   endtask

   // --------------------
   // model updates, a write to a full fifo is lost
   task automatic model_write(input axi_addr_t addr, input word_t data);
      case (addr)
         A_CSR0:  csr_m[0] = data;
         A_CSR1:  csr_m[1] = data;
         A_FIFO:
         begin
            if (ps_q.size() < `SHELL_FIFO_DEPTH)
               ps_q.push_back(data);
         end
         default: ;
      endcase
   endtask

   // a head read takes the word off the model queue
   function automatic word_t model_read(input axi_addr_t addr);
      case (addr)
         A_CSR0:  return csr_m[0];
         A_CSR1:  return csr_m[1];
         A_FIFO:  return pl_q.pop_front();
         A_COUNT: return word_t'(pl_q.size());
         A_FREE:  return word_t'(`SHELL_FIFO_DEPTH - ps_q.size());
         A_STAT:  return status_m;
         default: return '0;
      endcase
   endfunction

   // --------------------
   initial
   begin
      word_t data;
      word_t got;
      step_t st;
      awaddr   <= '0;
      awvalid  <= 1'b0;
      wdata    <= '0;
      wvalid   <= 1'b0;
      bready   <= 1'b0;
      araddr   <= '0;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      csr_in   <= '0;
      ps_yumi  <= 1'b0;
      pl_data  <= '0;
      pl_v     <= 1'b0;
      csr_m[0] = '0;
      csr_m[1] = '0;
      status_m = '0;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      abort    = 1'b0;
      lfsr_q   = 32'ha47c_1153;
      wait_high("S_AXI_ARESETN");
      for (int i = 0; i < N_STEPS && !abort; i++)
      begin
         st = steps[i];
         case (st.op)
            OP_WR:
            begin
               draw_word(data);
               axi_write(st.addr, data);
               model_write(st.addr, data);
               @(negedge clk);
               check_word("csr_data_o[0]", csr_out[0], csr_m[0]);
               check_word("csr_data_o[1]", csr_out[1], csr_m[1]);
            end
            OP_RD:
            begin
               axi_read(st.addr, got);
               check_word("s_axi_rdata_o", got, model_read(st.addr));
            end
            OP_RDX:
            begin
               axi_read(st.addr, got);
               check_word("s_axi_rdata_o", got, st.exp);
            end
            OP_PUSH:
            begin
               draw_word(data);
               pl_push(data);
               pl_q.push_back(data);
            end
            OP_POP:
            begin
               ps_pop(got);
               check_word("ps_to_pl_data_o", got, ps_q.pop_front());
            end
            OP_IDLE:
               idle_check(st.exp[0]);
            default:
            begin
               draw_word(data);
               @(posedge clk);
               csr_in   <= data;
               status_m = data;
            end
         endcase
      end
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== verilog/axil_read_ctrl.sv ====
`timescale 1ns/1ns
`include "shell_config.svh"

module axil_read_ctrl
(
   input  logic                 S_AXI_ACLK,
   input  logic                 S_AXI_ARESETN,
   input  shell_pkg::axi_addr_t araddr_i,
   input  logic                 arvalid_i,
   output logic                 arready_o,
   output shell_pkg::word_t     rdata_o,
   output logic                 rvalid_o,
   input  logic                 rready_i,
   reg_access_if.reader         acc
);
   import shell_pkg::*;

   localparam int IDX_W = `SHELL_ADDR_W - `SHELL_ADDR_LSB;

   logic             arready_q;
   logic             rvalid_q;
   logic [IDX_W-1:0] ar_idx;
   logic             rd_fire;
   word_t            rdata_q;

   // --------------------
   // address channel
   // handshake cycle, not taken while a response is still pending
   assign rd_fire = arready_q & arvalid_i & ~rvalid_q;
   assign ar_idx  = araddr_i[`SHELL_ADDR_W-1:`SHELL_ADDR_LSB];

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
      begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
      end
      else
      begin
         // single-cycle arready one clock after arvalid
         arready_q <= ~arready_q & arvalid_i;
         if (rd_fire)
            rvalid_q <= 1'b1;
         else if (rready_i)
            rvalid_q <= 1'b0;
      end
   end

   // decode straight from the bus, the address is stable until arready
   always_comb
   begin
      acc.rd_sel = '0;
      for (int i = 0; i < $bits(rd_sel_t); i++)
         acc.rd_sel[i] = rd_fire & (ar_idx == IDX_W'(i));
   end

   // --------------------
   // data channel, rdata stays put until the master takes it
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (rd_fire)
         rdata_q <= acc.rd_data;
   end

   assign arready_o = arready_q;
   assign rdata_o   = rdata_q;
   assign rvalid_o  = rvalid_q;

endmodule

// ==== verilog/axil_write_ctrl.sv ====
`timescale 1ns/1ns
`include "shell_config.svh"

module axil_write_ctrl
(
   input  logic                 S_AXI_ACLK,
   input  logic                 S_AXI_ARESETN,
   input  shell_pkg::axi_addr_t awaddr_i,
   input  logic                 awvalid_i,
   output logic                 awready_o,
   input  shell_pkg::word_t     wdata_i,
   input  logic                 wvalid_i,
   output logic                 wready_o,
   output logic                 bvalid_o,
   input  logic                 bready_i,
   reg_access_if.writer         acc
);
   import shell_pkg::*;

   localparam int IDX_W = `SHELL_ADDR_W - `SHELL_ADDR_LSB;

   logic             aw_en_q;
   logic             ready_q;
   logic             bvalid_q;
   logic [IDX_W-1:0] aw_idx_q;
   logic             start;
   logic             wr_fire;

   // --------------------
   // handshake
   // both channels must be valid, and only one write may be open
   assign start   = ~ready_q & awvalid_i & wvalid_i & aw_en_q;
   // address and data taken together in this cycle
   assign wr_fire = ready_q & awvalid_i & wvalid_i;

   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
      begin
         ready_q  <= 1'b0;
         aw_en_q  <= 1'b1;
         bvalid_q <= 1'b0;
      end
      else
      begin
         // one-cycle ready pulse shared by aw and w
         ready_q <= start;
         if (start)
            aw_en_q <= 1'b0;
         else if (bvalid_q && bready_i)
            aw_en_q <= 1'b1;
         // response follows the handshake, held until bready
         if (wr_fire && !bvalid_q)
            bvalid_q <= 1'b1;
         else if (bready_i)
            bvalid_q <= 1'b0;
      end
   end

   // keep only the word index of the address
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (start)
         aw_idx_q <= awaddr_i[`SHELL_ADDR_W-1:`SHELL_ADDR_LSB];
   end

   // --------------------
   // decode to a one-hot slot, unused words select nothing
   always_comb
   begin
      acc.wr_sel = '0;
      for (int i = 0; i < $bits(wr_sel_t); i++)
         acc.wr_sel[i] = wr_fire & (aw_idx_q == IDX_W'(i));
   end

   assign acc.wr_data = wdata_i;
   assign awready_o   = ready_q;
   assign wready_o    = ready_q;
   assign bvalid_o    = bvalid_q;

endmodule

// ==== verilog/reg_access_if.sv ====
`timescale 1ns/1ns

interface reg_access_if;
   import shell_pkg::*;

   // write side, already gated by the write handshake
   wr_sel_t wr_sel;
   word_t   wr_data;

   // read side, select gated by the read handshake
   rd_sel_t rd_sel;
   // combinational from rd_sel, valid in the same cycle
   word_t   rd_data;

   // axi write channel controller
   modport writer (output wr_sel, output wr_data);

   // axi read channel controller
   modport reader (output rd_sel, input rd_data);

   // register map and fifos
   modport target (input wr_sel, input wr_data, input rd_sel, output rd_data);

endinterface

// ==== verilog/shell_config.svh ====
`ifndef SHELL_CONFIG_SVH
`define SHELL_CONFIG_SVH

// bus word width in bits
`define SHELL_DATA_W 32

// byte offset bits below the word index
`define SHELL_ADDR_LSB 2

// byte address width, enough for six read words
`define SHELL_ADDR_W 5

// entries per word fifo, kept a power of two
`define SHELL_FIFO_DEPTH 4

`endif

// ==== verilog/shell_pkg.sv ====
`include "shell_config.svh"

package shell_pkg;

   // one bus data word and one byte address
   typedef logic [`SHELL_DATA_W-1:0] word_t;
   typedef logic [`SHELL_ADDR_W-1:0] axi_addr_t;

   // fifo occupancy, 0 up to full depth
   typedef logic [$clog2(`SHELL_FIFO_DEPTH+1)-1:0] count_t;

   // one-hot slot selects
   typedef logic [2:0] wr_sel_t;
   typedef logic [5:0] rd_sel_t;

   // write slots, byte address is index times 4
   localparam int WR_CSR0 = 0;
   localparam int WR_CSR1 = 1;
   localparam int WR_FIFO = 2;

   // read slots
   localparam int RD_CSR0       = 0;
   localparam int RD_CSR1       = 1;
   localparam int RD_FIFO_DATA  = 2;
   localparam int RD_FIFO_COUNT = 3;
   localparam int RD_FIFO_FREE  = 4;
   localparam int RD_STATUS     = 5;

endpackage

// ==== verilog/shell_regmap.sv ====
`timescale 1ns/1ns
`include "shell_config.svh"

module shell_regmap
(
   input  logic                   S_AXI_ACLK,
   input  logic                   S_AXI_ARESETN,
   reg_access_if.target           acc,
   output shell_pkg::word_t [1:0] csr_data_o,
   input  shell_pkg::word_t       csr_data_i,
   output shell_pkg::word_t       ps_to_pl_data_o,
   output logic                   ps_to_pl_v_o,
   input  logic                   ps_to_pl_yumi_i,
   input  shell_pkg::word_t       pl_to_ps_data_i,
   input  logic                   pl_to_ps_v_i,
   output logic                   pl_to_ps_ready_o
);
   import shell_pkg::*;

   word_t [1:0] csr_q;
   logic        ps_to_pl_ready;
   logic        ps_to_pl_push;
   count_t      ps_to_pl_count;
   word_t       pl_to_ps_head;
   logic        pl_to_ps_v;
   logic        pl_to_ps_pop;
   count_t      pl_to_ps_count;
   count_t      ps_to_pl_free;

   // --------------------
   // control registers
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
         csr_q <= '0;
      else
      begin
         if (acc.wr_sel[WR_CSR0])
            csr_q[0] <= acc.wr_data;
         if (acc.wr_sel[WR_CSR1])
            csr_q[1] <= acc.wr_data;
      end
   end

   assign csr_data_o = csr_q;

   // --------------------
   // ps to pl fifo, a word written while full is lost
   assign ps_to_pl_push = acc.wr_sel[WR_FIFO] & ps_to_pl_ready;

   word_fifo u_ps_to_pl_fifo
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .data_i        (acc.wr_data),
      .v_i           (ps_to_pl_push),
      .ready_o       (ps_to_pl_ready),
      .data_o        (ps_to_pl_data_o),
      .v_o           (ps_to_pl_v_o),
      .yumi_i        (ps_to_pl_yumi_i),
      .count_o       (ps_to_pl_count)
   );

   // --------------------
   // pl to ps fifo, popped by a head read when something is there
   assign pl_to_ps_pop = acc.rd_sel[RD_FIFO_DATA] & pl_to_ps_v;

   word_fifo u_pl_to_ps_fifo
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .data_i        (pl_to_ps_data_i),
      .v_i           (pl_to_ps_v_i),
      .ready_o       (pl_to_ps_ready_o),
      .data_o        (pl_to_ps_head),
      .v_o           (pl_to_ps_v),
      .yumi_i        (pl_to_ps_pop),
      .count_o       (pl_to_ps_count)
   );

   // free space seen by the processor
   assign ps_to_pl_free = count_t'(`SHELL_FIFO_DEPTH) - ps_to_pl_count;

   // --------------------
   // one-hot read mux, zero when nothing is selected
   always_comb
   begin
      acc.rd_data = '0;
      if (acc.rd_sel[RD_CSR0])
         acc.rd_data = acc.rd_data | csr_q[0];
      if (acc.rd_sel[RD_CSR1])
         acc.rd_data = acc.rd_data | csr_q[1];
      if (acc.rd_sel[RD_FIFO_DATA])
         acc.rd_data = acc.rd_data | pl_to_ps_head;
      // counts zero-extended to a full word
      if (acc.rd_sel[RD_FIFO_COUNT])
         acc.rd_data = acc.rd_data | word_t'(pl_to_ps_count);
      if (acc.rd_sel[RD_FIFO_FREE])
         acc.rd_data = acc.rd_data | word_t'(ps_to_pl_free);
      if (acc.rd_sel[RD_STATUS])
         acc.rd_data = acc.rd_data | csr_data_i;
   end

endmodule

// ==== verilog/word_fifo.sv ====
`timescale 1ns/1ns
`include "shell_config.svh"

module word_fifo
(
   input  logic              S_AXI_ACLK,
   input  logic              S_AXI_ARESETN,
   input  shell_pkg::word_t  data_i,
   input  logic              v_i,
   output logic              ready_o,
   output shell_pkg::word_t  data_o,
   output logic              v_o,
   input  logic              yumi_i,
   output shell_pkg::count_t count_o
);
   import shell_pkg::*;

   localparam int PTR_W = $clog2(`SHELL_FIFO_DEPTH);

   word_t            mem [`SHELL_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   count_t           count_q;
   logic             push;
   logic             pop;

   // ready when not full, valid when not empty
   assign ready_o = (count_q != count_t'(`SHELL_FIFO_DEPTH));
   assign v_o     = (count_q != '0);
   assign push    = v_i & ready_o;
   assign pop     = yumi_i & v_o;
   assign data_o  = mem[rd_ptr_q];
   assign count_o = count_q;

   // storage
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (push)
         mem[wr_ptr_q] <= data_i;
   end

   // pointers wrap on their own since depth is a power of two
   always_ff @(posedge S_AXI_ACLK)
   begin
      if (!S_AXI_ARESETN)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         // push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// ==== verilog/zynq_shell_top.sv ====
`timescale 1ns/1ns

module zynq_shell_top
(
   input  logic                   S_AXI_ACLK,
   input  logic                   S_AXI_ARESETN,
   // write address, data and response
   input  shell_pkg::axi_addr_t   s_axi_awaddr_i,
   input  logic                   s_axi_awvalid_i,
   output logic                   s_axi_awready_o,
   input  shell_pkg::word_t       s_axi_wdata_i,
   input  logic                   s_axi_wvalid_i,
   output logic                   s_axi_wready_o,
   output logic                   s_axi_bvalid_o,
   input  logic                   s_axi_bready_i,
   // read address and data
   input  shell_pkg::axi_addr_t   s_axi_araddr_i,
   input  logic                   s_axi_arvalid_i,
   output logic                   s_axi_arready_o,
   output shell_pkg::word_t       s_axi_rdata_o,
   output logic                   s_axi_rvalid_o,
   input  logic                   s_axi_rready_i,
   // client side
   output shell_pkg::word_t [1:0] csr_data_o,
   input  shell_pkg::word_t       csr_data_i,
   output shell_pkg::word_t       ps_to_pl_data_o,
   output logic                   ps_to_pl_v_o,
   input  logic                   ps_to_pl_yumi_i,
   input  shell_pkg::word_t       pl_to_ps_data_i,
   input  logic                   pl_to_ps_v_i,
   output logic                   pl_to_ps_ready_o
);

   // decoded accesses between the axi side and the register map
   reg_access_if acc ();

   axil_write_ctrl u_write_ctrl
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .awaddr_i      (s_axi_awaddr_i),
      .awvalid_i     (s_axi_awvalid_i),
      .awready_o     (s_axi_awready_o),
      .wdata_i       (s_axi_wdata_i),
      .wvalid_i      (s_axi_wvalid_i),
      .wready_o      (s_axi_wready_o),
      .bvalid_o      (s_axi_bvalid_o),
      .bready_i      (s_axi_bready_i),
      .acc           (acc.writer)
   );

   axil_read_ctrl u_read_ctrl
   (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .araddr_i      (s_axi_araddr_i),
      .arvalid_i     (s_axi_arvalid_i),
      .arready_o     (s_axi_arready_o),
      .rdata_o       (s_axi_rdata_o),
      .rvalid_o      (s_axi_rvalid_o),
      .rready_i      (s_axi_rready_i),
      .acc           (acc.reader)
   );

   shell_regmap u_regmap
   (
      .S_AXI_ACLK       (S_AXI_ACLK),
      .S_AXI_ARESETN    (S_AXI_ARESETN),
      .acc              (acc.target),
      .csr_data_o       (csr_data_o),
      .csr_data_i       (csr_data_i),
      .ps_to_pl_data_o  (ps_to_pl_data_o),
      .ps_to_pl_v_o     (ps_to_pl_v_o),
      .ps_to_pl_yumi_i  (ps_to_pl_yumi_i),
      .pl_to_ps_data_i  (pl_to_ps_data_i),
      .pl_to_ps_v_i     (pl_to_ps_v_i),
      .pl_to_ps_ready_o (pl_to_ps_ready_o)
   );

endmodule
